//--- rtl/mgnt_pkg.sv
package mgnt_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and sizes
    //////////////////////////////////////////////////////////////////////
    localparam int MGNT_REG_WIDTH = 32;
    localparam int MGNT_REG_BYTES = 4;
    localparam int DEST_COUNT     = 6;
    localparam int FLOW_WIDTH     = 120;
    localparam int HASH_WIDTH     = 12;
    localparam int TABLE_DEPTH    = 16;

    // pointer word holds the write flag in bit 15, the destination in
    // bits 14..8 and the register address in bits 7..0
    localparam logic [6:0] DEST_PORT0  = 7'h00;
    localparam logic [6:0] DEST_PORT1  = 7'h01;
    localparam logic [6:0] DEST_PORT2  = 7'h02;
    localparam logic [6:0] DEST_PORT3  = 7'h03;
    localparam logic [6:0] DEST_BE_SW  = 7'h40;
    localparam logic [6:0] DEST_TTE_SW = 7'h41;
    localparam logic [6:0] DEST_LOCAL  = 7'h7F;

    // hub local register map
    localparam logic [7:0] LOC_DEV_DATA      = 8'h01;
    localparam logic [7:0] LOC_TABLE_CTRL    = 8'h02;
    localparam logic [7:0] LOC_TABLE_HASH    = 8'h03;
    localparam logic [7:0] LOC_TABLE_ST_BASE = 8'h30;
    localparam logic [7:0] LOC_SW_ID         = 8'h80;
    localparam logic [7:0] LOC_SW_FTR        = 8'h81;
    localparam logic [7:0] LOC_SW_REV0       = 8'h82;
    localparam logic [7:0] LOC_SW_REV1       = 8'h83;

    // feature bits 1..4 are tte, ptp, lldp and rstp
    localparam logic [15:0] SW_ID_VAL  = 16'h1234;
    localparam logic [15:0] SW_FTR_VAL = 16'h001E;
    localparam logic [31:0] SW_REV_VAL = 32'h0002_0001;

    typedef enum logic [6:0] {
        OP_DEV_PTR    = 7'h00,
        OP_DEV_DATA   = 7'h01,
        OP_TABLE_CTRL = 7'h02,
        OP_TABLE_HASH = 7'h03,
        OP_TABLE_ST0  = 7'h30,
        OP_TABLE_ST1  = 7'h31,
        OP_TABLE_ST2  = 7'h32,
        OP_TABLE_ST3  = 7'h33,
        OP_TABLE_ST4  = 7'h34,
        OP_TABLE_ST5  = 7'h35,
        OP_TABLE_ST6  = 7'h36,
        OP_TABLE_ST7  = 7'h37
    } spi_op_e;

    typedef enum logic [2:0] {
        HUB_IDLE,
        HUB_DECODE,
        HUB_LOAD,
        HUB_XFER,
        HUB_WAIT_ACK,
        HUB_LOCAL,
        HUB_BUFFER,
        HUB_RETURN
    } hub_state_e;

    typedef enum logic [1:0] {
        FT_CMD_UPDATE = 2'd1,
        FT_CMD_CLEAR  = 2'd2
    } ft_cmd_e;

endpackage

//--- rtl/mgnt_reg_agent.sv
`timescale 1ns/1ns

module mgnt_reg_agent import mgnt_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       req_valid,
    input  logic       req_wr,
    input  logic [7:0] req_addr,
    input  logic [7:0] req_data,
    input  logic       req_data_valid,
    output logic [7:0] resp_data,
    output logic       resp_data_valid,
    output logic       req_ack
);

    logic [MGNT_REG_WIDTH-1:0] regs [16];
    logic [MGNT_REG_WIDTH-9:0] wr_shift;
    logic [MGNT_REG_WIDTH-1:0] rd_shift;
    logic                      valid_q;
    logic                      req_new;
    logic                      wr_active;
    logic                      rd_active;
    logic [1:0]                byte_cnt;
    logic                      byte_last;

    // a request starts on the rising edge of valid
    assign req_new   = req_valid && !valid_q;
    assign byte_last = (byte_cnt == 2'(MGNT_REG_BYTES - 1));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q   <= 1'b0;
            wr_active <= 1'b0;
            rd_active <= 1'b0;
            byte_cnt  <= '0;
            req_ack   <= 1'b0;
            wr_shift  <= '0;
            rd_shift  <= '0;
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end
        else begin
            valid_q <= req_valid;
            req_ack <= 1'b0;
            if (req_new) begin
                byte_cnt  <= '0;
                wr_active <= req_wr;
                rd_active <= !req_wr;
                rd_shift  <= regs[req_addr[3:0]];
            end
            else if (wr_active && req_data_valid) begin
                // collect bytes msb first
                wr_shift <= {wr_shift[MGNT_REG_WIDTH-17:0], req_data};
                byte_cnt <= byte_cnt + 1'b1;
                if (byte_last) begin
                    regs[req_addr[3:0]] <= {wr_shift, req_data};
                    wr_active           <= 1'b0;
                    req_ack             <= 1'b1;
                end
            end
            else if (rd_active) begin
                rd_shift <= rd_shift << 8;
                byte_cnt <= byte_cnt + 1'b1;
                if (byte_last) begin
                    rd_active <= 1'b0;
                    req_ack   <= 1'b1;
                end
            end
        end
    end

    assign resp_data       = rd_shift[MGNT_REG_WIDTH-1 -: 8];
    assign resp_data_valid = rd_active;

endmodule

//--- rtl/flow_table.sv
`timescale 1ns/1ns

module flow_table import mgnt_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ft_update,
    input  logic                  ft_clear,
    input  logic [FLOW_WIDTH-1:0] flow,
    input  logic [HASH_WIDTH-1:0] hash,
    output logic                  ft_ack,
    input  logic [HASH_WIDTH-1:0] lookup_hash,
    output logic                  lookup_hit,
    output logic [FLOW_WIDTH-1:0] lookup_flow
);

    logic [FLOW_WIDTH-1:0]  flow_mem [TABLE_DEPTH];
    logic [TABLE_DEPTH-1:0] entry_valid;
    logic                   upd_ack;
    logic                   clr_active;
    logic [3:0]             clr_cnt;
    logic [3:0]             lookup_idx;

    // entries are indexed by the low hash bits
    assign lookup_idx = lookup_hash[3:0];
    assign ft_ack     = upd_ack | clr_active;

    always_ff @(posedge clk) begin
        if (ft_update) begin
            flow_mem[hash[3:0]] <= flow;
        end
        lookup_flow <= flow_mem[lookup_idx];
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            entry_valid <= '0;
            upd_ack     <= 1'b0;
            clr_active  <= 1'b0;
            clr_cnt     <= '0;
            lookup_hit  <= 1'b0;
        end
        else begin
            upd_ack <= ft_update;
            if (ft_clear) begin
                clr_active <= 1'b1;
                clr_cnt    <= '0;
            end
            else if (clr_active) begin
                // one entry per cycle
                entry_valid[clr_cnt] <= 1'b0;
                clr_cnt              <= clr_cnt + 1'b1;
                if (clr_cnt == 4'(TABLE_DEPTH - 1)) begin
                    clr_active <= 1'b0;
                end
            end
            else if (ft_update) begin
                entry_valid[hash[3:0]] <= 1'b1;
            end
            // all-zero key is never a hit
            lookup_hit <= entry_valid[lookup_idx] && (flow_mem[lookup_idx] != '0);
        end
    end

endmodule

//--- rtl/mgnt_reg_hub.sv
`timescale 1ns/1ns

module mgnt_reg_hub import mgnt_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      spi_wr,
    input  spi_op_e                   spi_op,
    input  logic [15:0]               spi_din,
    output logic [15:0]               spi_dout,
    output logic                      spi_done,
    output logic [DEST_COUNT-1:0]     sys_req_valid,
    output logic                      sys_req_wr,
    output logic [7:0]                sys_req_addr,
    input  logic [DEST_COUNT-1:0]     sys_req_ack,
    output logic [7:0]                sys_req_data,
    output logic                      sys_req_data_valid,
    input  logic [8*DEST_COUNT-1:0]   sys_resp_data,
    input  logic [DEST_COUNT-1:0]     sys_resp_data_valid,
    output logic                      ft_update,
    output logic                      ft_clear,
    input  logic                      ft_ack,
    output logic [FLOW_WIDTH-1:0]     flow,
    output logic [HASH_WIDTH-1:0]     hash
);

    hub_state_e                 state;
    logic [15:0]                dev_ptr;
    logic [15:0]                dev_data;
    logic [15:0]                ret_data;
    logic [MGNT_REG_WIDTH-1:0]  tx_shift;
    logic [MGNT_REG_WIDTH-1:0]  rx_shift;
    logic [1:0]                 byte_cnt;
    logic                       byte_last;
    logic [DEST_COUNT-1:0]      dest_hot;
    logic [7:0]                 lane_data;
    logic                       lane_valid;
    logic                       lane_ack;
    logic [15:0]                local_rd;
    logic [127:0]               table_reg;
    logic [HASH_WIDTH-1:0]      table_hash;
    logic [1:0]                 ft_bsy;
    ft_cmd_e                    ft_cmd;
    logic                       cmd_ptr;
    logic                       cmd_data;
    logic                       cmd_ctrl;

    // pointer and buffer strobes only count while idle
    assign cmd_ptr   = spi_wr && (spi_op == OP_DEV_PTR) && (state == HUB_IDLE);
    assign cmd_data  = spi_wr && (spi_op == OP_DEV_DATA) && (state == HUB_IDLE);
    assign cmd_ctrl  = spi_wr && (spi_op == OP_TABLE_CTRL);
    assign ft_cmd    = ft_cmd_e'(spi_din[1:0]);
    assign byte_last = (byte_cnt == 2'(MGNT_REG_BYTES - 1));

    // destination code to agent select
    always_comb begin
        case (dev_ptr[14:8])
            DEST_PORT0:  dest_hot = 6'b000001;
            DEST_PORT1:  dest_hot = 6'b000010;
            DEST_PORT2:  dest_hot = 6'b000100;
            DEST_PORT3:  dest_hot = 6'b001000;
            DEST_BE_SW:  dest_hot = 6'b010000;
            DEST_TTE_SW: dest_hot = 6'b100000;
            default:     dest_hot = '0;
        endcase
    end

    // pick the byte lane of the agent being served
    always_comb begin
        lane_data = '0;
        for (int i = 0; i < DEST_COUNT; i++) begin
            if (sys_req_valid[i]) begin
                lane_data = sys_resp_data[8*i +: 8];
            end
        end
    end

    assign lane_valid = |(sys_resp_data_valid & sys_req_valid);
    assign lane_ack   = |(sys_req_ack & sys_req_valid);

    // local register read mux
    always_comb begin
        local_rd = '0;
        if (dev_ptr[7:3] == LOC_TABLE_ST_BASE[7:3]) begin
            local_rd = table_reg[16*dev_ptr[2:0] +: 16];
        end
        else begin
            case (dev_ptr[7:0])
                LOC_DEV_DATA:   local_rd = dev_data;
                LOC_TABLE_CTRL: local_rd = {14'b0, ft_bsy};
                LOC_TABLE_HASH: local_rd = {{(16-HASH_WIDTH){1'b0}}, table_hash};
                LOC_SW_ID:      local_rd = SW_ID_VAL;
                LOC_SW_FTR:     local_rd = SW_FTR_VAL;
                LOC_SW_REV0:    local_rd = SW_REV_VAL[15:0];
                LOC_SW_REV1:    local_rd = SW_REV_VAL[31:16];
                default:        local_rd = '0;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // command sequencer
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state              <= HUB_IDLE;
            dev_ptr            <= '0;
            dev_data           <= '0;
            ret_data           <= '0;
            tx_shift           <= '0;
            rx_shift           <= '0;
            byte_cnt           <= '0;
            sys_req_valid      <= '0;
            sys_req_wr         <= 1'b0;
            sys_req_data_valid <= 1'b0;
            spi_dout           <= '0;
            spi_done           <= 1'b0;
        end
        else begin
            spi_done <= 1'b0;
            case (state)
                HUB_IDLE: begin
                    if (cmd_ptr) begin
                        dev_ptr <= spi_din;
                        state   <= HUB_DECODE;
                    end
                    else if (cmd_data) begin
                        dev_data <= spi_din;
                        state    <= HUB_BUFFER;
                    end
                end
                HUB_DECODE: begin
                    if (dest_hot != '0) begin
                        sys_req_valid <= dest_hot;
                        sys_req_wr    <= dev_ptr[15];
                        state         <= HUB_LOAD;
                    end
                    else if (dev_ptr[14:8] == DEST_LOCAL) begin
                        state <= HUB_LOCAL;
                    end
                    else begin
                        // unknown destination answers zero
                        ret_data <= '0;
                        state    <= HUB_RETURN;
                    end
                end
                HUB_LOAD: begin
                    tx_shift           <= {{(MGNT_REG_WIDTH-16){1'b0}}, dev_data};
                    rx_shift           <= '0;
                    byte_cnt           <= '0;
                    sys_req_data_valid <= sys_req_wr;
                    state              <= HUB_XFER;
                end
                HUB_XFER: begin
                    if (sys_req_wr) begin
                        tx_shift <= tx_shift << 8;
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_last) begin
                            sys_req_data_valid <= 1'b0;
                            state              <= HUB_WAIT_ACK;
                        end
                    end
                    else if (lane_valid) begin
                        rx_shift <= {rx_shift[MGNT_REG_WIDTH-9:0], lane_data};
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_last) begin
                            state <= HUB_WAIT_ACK;
                        end
                    end
                end
                HUB_WAIT_ACK: begin
                    if (lane_ack) begin
                        sys_req_valid <= '0;
                        sys_req_wr    <= 1'b0;
                        ret_data      <= rx_shift[15:0];
                        state         <= HUB_RETURN;
                    end
                end
                HUB_LOCAL: begin
                    ret_data <= local_rd;
                    state    <= HUB_RETURN;
                end
                HUB_BUFFER: begin
                    ret_data <= dev_data;
                    state    <= HUB_RETURN;
                end
                HUB_RETURN: begin
                    spi_dout <= ret_data;
                    spi_done <= 1'b1;
                    state    <= HUB_IDLE;
                end
                default: state <= HUB_IDLE;
            endcase
        end
    end

    assign sys_req_addr = dev_ptr[7:0];
    // msb first on the byte lane
    assign sys_req_data = tx_shift[MGNT_REG_WIDTH-1 -: 8];

    //////////////////////////////////////////////////////////////////////
    // flow table staging and control
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            table_reg  <= '0;
            table_hash <= '0;
        end
        else if (spi_wr) begin
            if (spi_op == OP_TABLE_HASH) begin
                table_hash <= spi_din[HASH_WIDTH-1:0];
            end
            if (spi_op >= OP_TABLE_ST0 && spi_op <= OP_TABLE_ST7) begin
                table_reg[16*spi_op[2:0] +: 16] <= spi_din;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ft_update <= 1'b0;
            ft_clear  <= 1'b0;
            ft_bsy    <= '0;
        end
        else begin
            ft_update <= cmd_ctrl && (ft_cmd == FT_CMD_UPDATE);
            ft_clear  <= cmd_ctrl && (ft_cmd == FT_CMD_CLEAR);
            // busy from the command until the table drops its ack
            if (cmd_ctrl && (ft_cmd == FT_CMD_UPDATE || ft_cmd == FT_CMD_CLEAR)) begin
                ft_bsy <= {ft_cmd == FT_CMD_CLEAR, ft_cmd == FT_CMD_UPDATE};
            end
            else if (!ft_update && !ft_clear && !ft_ack) begin
                ft_bsy <= '0;
            end
        end
    end

    assign flow = table_reg[FLOW_WIDTH-1:0];
    assign hash = table_hash;

endmodule

//--- rtl/mgnt_subsystem.sv
`timescale 1ns/1ns

module mgnt_subsystem import mgnt_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  spi_wr,
    input  spi_op_e               spi_op,
    input  logic [15:0]           spi_din,
    output logic [15:0]           spi_dout,
    output logic                  spi_done,
    input  logic [HASH_WIDTH-1:0] lookup_hash,
    output logic                  lookup_hit,
    output logic [FLOW_WIDTH-1:0] lookup_flow
);

    logic [DEST_COUNT-1:0]   sys_req_valid;
    logic                    sys_req_wr;
    logic [7:0]              sys_req_addr;
    logic [DEST_COUNT-1:0]   sys_req_ack;
    logic [7:0]              sys_req_data;
    logic                    sys_req_data_valid;
    logic [8*DEST_COUNT-1:0] sys_resp_data;
    logic [DEST_COUNT-1:0]   sys_resp_data_valid;
    logic                    ft_update;
    logic                    ft_clear;
    logic                    ft_ack;
    logic [FLOW_WIDTH-1:0]   flow;
    logic [HASH_WIDTH-1:0]   hash;

    mgnt_reg_hub hub0 (
        .clk                 (clk),
        .rst                 (rst),
        .spi_wr              (spi_wr),
        .spi_op              (spi_op),
        .spi_din             (spi_din),
        .spi_dout            (spi_dout),
        .spi_done            (spi_done),
        .sys_req_valid       (sys_req_valid),
        .sys_req_wr          (sys_req_wr),
        .sys_req_addr        (sys_req_addr),
        .sys_req_ack         (sys_req_ack),
        .sys_req_data        (sys_req_data),
        .sys_req_data_valid  (sys_req_data_valid),
        .sys_resp_data       (sys_resp_data),
        .sys_resp_data_valid (sys_resp_data_valid),
        .ft_update           (ft_update),
        .ft_clear            (ft_clear),
        .ft_ack              (ft_ack),
        .flow                (flow),
        .hash                (hash)
    );

    // lanes 0..3 mac ports, 4 best-effort core, 5 time-triggered core
    for (genvar i = 0; i < DEST_COUNT; i++) begin : g_agent
        mgnt_reg_agent agent (
            .clk             (clk),
            .rst             (rst),
            .req_valid       (sys_req_valid[i]),
            .req_wr          (sys_req_wr),
            .req_addr        (sys_req_addr),
            .req_data        (sys_req_data),
            .req_data_valid  (sys_req_data_valid),
            .resp_data       (sys_resp_data[8*i +: 8]),
            .resp_data_valid (sys_resp_data_valid[i]),
            .req_ack         (sys_req_ack[i])
        );
    end

    flow_table ft0 (
        .clk         (clk),
        .rst         (rst),
        .ft_update   (ft_update),
        .ft_clear    (ft_clear),
        .flow        (flow),
        .hash        (hash),
        .ft_ack      (ft_ack),
        .lookup_hash (lookup_hash),
        .lookup_hit  (lookup_hit),
        .lookup_flow (lookup_flow)
    );

endmodule

//--- verification/mgnt_reg_hub_assertions.sv
`timescale 1ns/1ns

module mgnt_reg_hub_assertions import mgnt_pkg::*; (
    input logic                  clk,
    input logic                  rst,
    input logic [DEST_COUNT-1:0] sys_req_valid,
    input logic                  sys_req_wr,
    input logic                  sys_req_data_valid,
    input logic                  ft_update,
    input logic                  ft_clear,
    input logic                  spi_done
);

    // at most one agent selected
    valid_onehot: assert property (@(posedge clk) disable iff (!rst)
        $onehot0(sys_req_valid))
        else $error("sys_req_valid selects more than one agent");

    // write bytes only go out during a write request
    data_in_write: assert property (@(posedge clk) disable iff (!rst)
        sys_req_data_valid |-> sys_req_wr)
        else $error("sys_req_data_valid high outside a write request");

    table_cmd_excl: assert property (@(posedge clk) disable iff (!rst)
        !(ft_update && ft_clear))
        else $error("ft_update and ft_clear high together");

    done_pulse: assert property (@(posedge clk) disable iff (!rst)
        spi_done |=> !spi_done)
        else $error("spi_done high for two cycles");

endmodule

//--- verification/mgnt_subsystem_tb.sv
`timescale 1ns/1ns

module mgnt_subsystem_tb import mgnt_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 200;
    localparam int POLL_LIMIT     = 20;

    logic                  clk;
    logic                  rst;
    logic                  spi_wr;
    spi_op_e               spi_op;
    logic [15:0]           spi_din;
    logic [15:0]           spi_dout;
    logic                  spi_done;
    logic [HASH_WIDTH-1:0] lookup_hash;
    logic                  lookup_hit;
    logic [FLOW_WIDTH-1:0] lookup_flow;

    integer seed;
    int     error_count;
    int     check_count;

    // reference model state
    logic [31:0]           remote_model [DEST_COUNT][16];
    logic [15:0]           buf_model;
    logic [15:0]           stage_model [8];
    logic [HASH_WIDTH-1:0] hash_model;
    logic [FLOW_WIDTH-1:0] ft_model [TABLE_DEPTH];
    logic [TABLE_DEPTH-1:0] ft_valid;
    logic [6:0]            dest_codes [DEST_COUNT];

    mgnt_subsystem dut0 (
        .clk         (clk),
        .rst         (rst),
        .spi_wr      (spi_wr),
        .spi_op      (spi_op),
        .spi_din     (spi_din),
        .spi_dout    (spi_dout),
        .spi_done    (spi_done),
        .lookup_hash (lookup_hash),
        .lookup_hit  (lookup_hit),
        .lookup_flow (lookup_flow)
    );

    bind mgnt_reg_hub mgnt_reg_hub_assertions hub_asrt (
        .clk                (clk),
        .rst                (rst),
        .sys_req_valid      (sys_req_valid),
        .sys_req_wr         (sys_req_wr),
        .sys_req_data_valid (sys_req_data_valid),
        .ft_update          (ft_update),
        .ft_clear           (ft_clear),
        .spi_done           (spi_done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // command helpers
    //////////////////////////////////////////////////////////////////////
    task automatic drive_cmd(input spi_op_e op, input logic [15:0] din);
        @(negedge clk);
        spi_wr  = 1'b1;
        spi_op  = op;
        spi_din = din;
        @(negedge clk);
        spi_wr  = 1'b0;
    endtask

    // strobe a command, then wait for spi_done
    task automatic run_cmd(input spi_op_e op, input logic [15:0] din, output logic [15:0] dout);
        int waited;
        waited = 0;
        drive_cmd(op, din);
        while (!spi_done && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (spi_done) begin
            dout = spi_dout;
        end
        else begin
            $display("timeout: no spi_done for op %h with data %h", op, din);
            error_count++;
            dout = 'x;
        end
    endtask

    task automatic read_ptr(input logic [6:0] dest, input logic [7:0] addr,
                            output logic [15:0] dout);
        run_cmd(OP_DEV_PTR, {1'b0, dest, addr}, dout);
    endtask

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        check_count++;
        if (act !== exp) begin
            $display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs0, input int checks0);
        $display("test %s finished: %0d checks, %0d errors", name,
                 check_count - checks0, error_count - errs0);
    endtask

    // lookup result is registered, so sample one cycle later
    task automatic lookup_entry(input logic [HASH_WIDTH-1:0] h, output logic hit,
                                output logic [FLOW_WIDTH-1:0] fl);
        @(negedge clk);
        lookup_hash = h;
        @(negedge clk);
        hit = lookup_hit;
        fl  = lookup_flow;
    endtask

    task automatic wait_table_idle(input string name);
        logic [15:0] status;
        int          polls;
        status = 16'hffff;
        polls  = 0;
        while (status !== 16'h0000 && polls < POLL_LIMIT) begin
            read_ptr(DEST_LOCAL, LOC_TABLE_CTRL, status);
            polls++;
        end
        if (status !== 16'h0000) begin
            $display("%s: table status never returned to zero", name);
            error_count++;
        end
    endtask

    function automatic logic [FLOW_WIDTH-1:0] staged_flow();
        logic [127:0] flat;
        for (int k = 0; k < 8; k++) begin
            flat[16*k +: 16] = stage_model[k];
        end
        return flat[FLOW_WIDTH-1:0];
    endfunction

    task automatic load_stage(input int k, input logic [15:0] v);
        drive_cmd(spi_op_e'(OP_TABLE_ST0 + k), v);
        stage_model[k] = v;
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////
    task automatic test_ident();
        logic [15:0] dout;
        logic [15:0] exp [4];
        int          e0;
        int          c0;
        e0 = error_count;
        c0 = check_count;
        exp[0] = SW_ID_VAL;
        exp[1] = SW_FTR_VAL;
        exp[2] = SW_REV_VAL[15:0];
        exp[3] = SW_REV_VAL[31:16];
        for (int i = 0; i < 4; i++) begin
            read_ptr(DEST_LOCAL, LOC_SW_ID + 8'(i), dout);
            check_value($sformatf("ident addr %0h", LOC_SW_ID + i), exp[i], dout);
        end
        report_test("ident", e0, c0);
    endtask

    task automatic test_buffer();
        logic [15:0] dout;
        int          e0;
        int          c0;
        e0 = error_count;
        c0 = check_count;
        repeat (4) begin
            buf_model = 16'($random(seed));
            run_cmd(OP_DEV_DATA, buf_model, dout);
            check_value("buffer write return", buf_model, dout);
            read_ptr(DEST_LOCAL, LOC_DEV_DATA, dout);
            check_value("buffer readback", buf_model, dout);
        end
        report_test("buffer", e0, c0);
    endtask

    task automatic test_remote();
        logic [15:0] dout;
        logic [15:0] v;
        logic [7:0]  addr;
        logic [7:0]  last_addr;
        int          d;
        int          last_d;
        int          e0;
        int          c0;
        e0 = error_count;
        c0 = check_count;
        last_d    = -1;
        last_addr = '0;
        for (int n = 0; n < 40; n++) begin
            d    = ($random(seed) & 32'h7fff_ffff) % DEST_COUNT;
            addr = 8'($random(seed));
            if ($random(seed) & 1) begin
                v = 16'($random(seed));
                run_cmd(OP_DEV_DATA, v, dout);
                buf_model = v;
                run_cmd(OP_DEV_PTR, {1'b1, dest_codes[d], addr}, dout);
                // upper bytes go out as zero from the 16-bit buffer
                remote_model[d][addr[3:0]] = {16'h0000, v};
                last_d    = d;
                last_addr = addr;
            end
            else begin
                read_ptr(dest_codes[d], addr, dout);
                check_value($sformatf("remote read dest %0h addr %0h", dest_codes[d], addr),
                            remote_model[d][addr[3:0]][15:0], dout);
            end
        end
        // read back the last register written
        if (last_d >= 0) begin
            read_ptr(dest_codes[last_d], last_addr, dout);
            check_value($sformatf("remote readback dest %0h addr %0h",
                                  dest_codes[last_d], last_addr),
                        remote_model[last_d][last_addr[3:0]][15:0], dout);
        end
        report_test("remote", e0, c0);
    endtask

    task automatic test_staging();
        logic [15:0] dout;
        int          e0;
        int          c0;
        e0 = error_count;
        c0 = check_count;
        repeat (16) begin
            load_stage(($random(seed) & 32'h7fff_ffff) % 8, 16'($random(seed)));
        end
        hash_model = HASH_WIDTH'($random(seed));
        drive_cmd(OP_TABLE_HASH, {4'h0, hash_model});
        for (int k = 0; k < 8; k++) begin
            read_ptr(DEST_LOCAL, LOC_TABLE_ST_BASE + 8'(k), dout);
            check_value($sformatf("staging word %0d", k), stage_model[k], dout);
        end
        read_ptr(DEST_LOCAL, LOC_TABLE_HASH, dout);
        check_value("table hash", {4'h0, hash_model}, dout);
        report_test("staging", e0, c0);
    endtask

    task automatic check_all_entries(input string name);
        logic                  hit;
        logic                  exp_hit;
        logic [FLOW_WIDTH-1:0] fl;
        for (int i = 0; i < TABLE_DEPTH; i++) begin
            lookup_entry({8'($random(seed)), 4'(i)}, hit, fl);
            // an all-zero key never hits
            exp_hit = ft_valid[i] && (ft_model[i] != '0);
            check_value($sformatf("%s hit %0d", name, i), exp_hit, hit);
            if (exp_hit) begin
                check_value($sformatf("%s flow %0d", name, i), ft_model[i], fl);
            end
        end
    endtask

    task automatic test_flow();
        logic [15:0] status;
        int          e0;
        int          c0;
        e0 = error_count;
        c0 = check_count;
        repeat (5) begin
            for (int k = 0; k < 8; k++) begin
                load_stage(k, 16'($random(seed)));
            end
            hash_model = HASH_WIDTH'($random(seed));
            drive_cmd(OP_TABLE_HASH, {4'h0, hash_model});
            drive_cmd(OP_TABLE_CTRL, 16'(FT_CMD_UPDATE));
            ft_model[hash_model[3:0]] = staged_flow();
            ft_valid[hash_model[3:0]] = 1'b1;
            wait_table_idle("flow update");
        end
        check_all_entries("after update");
        drive_cmd(OP_TABLE_CTRL, 16'(FT_CMD_CLEAR));
        ft_valid = '0;
        // clear keeps the table busy for many cycles
        read_ptr(DEST_LOCAL, LOC_TABLE_CTRL, status);
        check_count++;
        if (status === 16'h0000) begin
            $display("flow clear: table status not busy during clear");
            error_count++;
        end
        wait_table_idle("flow clear");
        check_all_entries("after clear");
        report_test("flow table", e0, c0);
    endtask

    task automatic test_unknown();
        logic [15:0] dout;
        logic [6:0]  code;
        int          e0;
        int          c0;
        e0 = error_count;
        c0 = check_count;
        repeat (4) begin
            // load a nonzero buffer first
            buf_model = 16'($random(seed)) | 16'h0001;
            run_cmd(OP_DEV_DATA, buf_model, dout);
            // 0x10..0x3f holds no agent
            code = 7'h10 + 7'(($random(seed) & 32'h7fff_ffff) % 48);
            read_ptr(code, 8'($random(seed)), dout);
            check_value($sformatf("unknown dest %0h", code), 16'h0000, dout);
        end
        report_test("unknown dest", e0, c0);
    endtask

    initial begin
        seed        = 93;
        error_count = 0;
        check_count = 0;
        rst         = 1'b0;
        spi_wr      = 1'b0;
        spi_op      = OP_DEV_PTR;
        spi_din     = '0;
        lookup_hash = '0;
        buf_model   = '0;
        hash_model  = '0;
        ft_valid    = '0;
        dest_codes  = '{DEST_PORT0, DEST_PORT1, DEST_PORT2, DEST_PORT3, DEST_BE_SW, DEST_TTE_SW};
        for (int d = 0; d < DEST_COUNT; d++) begin
            for (int a = 0; a < 16; a++) begin
                remote_model[d][a] = '0;
            end
        end
        for (int k = 0; k < 8; k++) begin
            stage_model[k] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        test_ident();
        test_buffer();
        test_remote();
        test_staging();
        test_flow();
        test_unknown();

        $display("total: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end
        else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- mgnt_subsystem.f
rtl/mgnt_pkg.sv
rtl/mgnt_reg_agent.sv
rtl/flow_table.sv
rtl/mgnt_reg_hub.sv
rtl/mgnt_subsystem.sv
verification/mgnt_reg_hub_assertions.sv
verification/mgnt_subsystem_tb.sv
